// File: all.f
+incdir+include
hw/sifhPkg.sv
hw/sifhSampleIf.sv
hw/sifhSeqCounter.sv
hw/sifhPassFsm.sv
hw/sifhWindowFilter.sv
hw/sifhHistPeak.sv
hw/sifhTop.sv
dv/sifhTop_chk.sv
dv/sifhTb.sv

// File: dv/sifhTb.sv
/* directed testbench for the peak finder, drives coarse and fine passes into sifhTop
   and checks the published peaks against a model of the histogram rules */
`timescale 1ns/1ps
`include "sifh_consts.svh"

module sifhTb;

    localparam int PASS_LEN = `SIFH_PIXELS * `SIFH_DATA_NUM * `SIFH_ACQ_NUM;
    localparam int TIMEOUT = 50;

    logic clk;
    logic combin_res;
    logic wrEn;
    logic [`SIFH_NP-1:0] data;
    logic ready;
    logic [`SIFH_PIXELS*`SIFH_NP-1:0] result;
    logic resultValid;

    // one frame of stimulus, in arrival order
    logic [7:0] coarseData [PASS_LEN];
    logic [7:0] fineData [PASS_LEN];
    // model outputs
    int loModel [`SIFH_PIXELS];
    int expResult [`SIFH_PIXELS];
    logic [31:0] lfsr;
    int errors;
    int testsRun;
    int testsFailed;
    bit timedOut;

    sifhTop dut (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data),
        .ready(ready), .result(result), .resultValid(resultValid)
    );

    always #50 clk = ~clk;

    // ******************************
    // helpers
    // ******************************
    // galois step, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit taken
    task automatic takeBits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic checkEq(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%0h expected 0x%0h", sig, got, exp);
            errors++;
        end
    endtask

    // coarse mode gives the windows, fine mode the expected results
    task automatic modelPass(input bit fineMode);
        int cnt [`SIFH_PIXELS][16];
        int best [`SIFH_PIXELS];
        int peak [`SIFH_PIXELS];
        int p;
        int b;
        int base;
        for (int i = 0; i < `SIFH_PIXELS; i++) begin
            best[i] = 0;
            peak[i] = 0;
            for (int j = 0; j < 16; j++) begin
                cnt[i][j] = 0;
            end
        end
        for (int k = 0; k < PASS_LEN; k++) begin
            // sample index fastest, then pixel
            p = (k / `SIFH_DATA_NUM) % `SIFH_PIXELS;
            b = fineMode ? int'(fineData[k]) - loModel[p] : int'(coarseData[k]) / 16;
            // fine samples outside lo..lo+15 are dropped
            if (b >= 0 && b < 16) begin
                cnt[p][b]++;
                if (cnt[p][b] > best[p]) begin
                    best[p] = cnt[p][b];
                    peak[p] = b;
                end
            end
        end
        for (int i = 0; i < `SIFH_PIXELS; i++) begin
            base = peak[i] * 16 - `SIFH_HALF_WIN;
            if (fineMode) begin
                expResult[i] = loModel[i] + peak[i];
            end else begin
                loModel[i] = (base < 0) ? 0 : ((base > 240) ? 240 : base);
            end
        end
    endtask

    // waits for ready, junk on wrEn meanwhile if asked
    task automatic sendSample(input logic [7:0] value, input bit garbage);
        int waited;
        logic [7:0] junk;
        waited = 0;
        if (timedOut) return;
        while (!ready) begin
            if (waited == TIMEOUT) begin
                $display("timeout, ready stayed low for %0d cycles", TIMEOUT);
                timedOut = 1;
                wrEn = 0;
                return;
            end
            wrEn = 0;
            if (garbage) begin
                takeBits(8, junk);
                wrEn = 1;
                data = junk;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        wrEn = 1;
        data = value;
        @(posedge clk);
        #1;
        wrEn = 0;
    endtask

    task automatic waitResult(input bit garbage);
        int waited;
        logic [7:0] junk;
        waited = 0;
        if (timedOut) return;
        while (!resultValid) begin
            if (waited == TIMEOUT) begin
                $display("timeout, no resultValid within %0d cycles", TIMEOUT);
                timedOut = 1;
                wrEn = 0;
                return;
            end
            wrEn = 0;
            // junk only where it cannot be accepted
            if (garbage && !ready) begin
                takeBits(8, junk);
                wrEn = 1;
                data = junk;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        wrEn = 0;
    endtask

    task automatic endTest(input string name, input int errBefore);
        testsRun++;
        if (timedOut || errors != errBefore) begin
            testsFailed++;
            $display("test %-10s FAILED", name);
        end else begin
            $display("test %-10s ok", name);
        end
    endtask

    // both passes of one frame, then the result check
    task automatic runFrame(input string name, input bit garbage);
        int errBefore;
        errBefore = errors;
        modelPass(0);
        modelPass(1);
        for (int k = 0; k < PASS_LEN; k++) begin
            sendSample(coarseData[k], garbage);
        end
        for (int k = 0; k < PASS_LEN; k++) begin
            sendSample(fineData[k], garbage);
        end
        waitResult(garbage);
        if (!timedOut) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                checkEq($sformatf("result[%0d]", p), 32'(result[p*`SIFH_NP +: `SIFH_NP]),
                        32'(expResult[p]));
            end
        end
        endTest(name, errBefore);
    endtask

    // ******************************
    // directed tests
    // ******************************
    task automatic testReset();
        int errBefore;
        errBefore = errors;
        checkEq("ready", 32'(ready), 32'd1);
        checkEq("resultValid", 32'(resultValid), 32'd0);
        checkEq("result", 32'(result), 32'd0);
        endTest("reset", errBefore);
    endtask

    // distinct centre per pixel, small spread
    task automatic testClustered();
        int centre [`SIFH_PIXELS];
        int p;
        centre = '{40, 100, 171, 226};
        for (int k = 0; k < PASS_LEN; k++) begin
            p = (k / `SIFH_DATA_NUM) % `SIFH_PIXELS;
            coarseData[k] = 8'(centre[p] + (k * 7) % 9 - 4);
            fineData[k] = 8'(centre[p] + (k * 5) % 7 - 3);
        end
        runFrame("clustered", 0);
    endtask

    // bins 0 and 15, fine hits at the window edges
    task automatic testClamp();
        int p;
        int a;
        for (int k = 0; k < PASS_LEN; k++) begin
            p = (k / `SIFH_DATA_NUM) % `SIFH_PIXELS;
            a = k / (`SIFH_DATA_NUM * `SIFH_PIXELS);
            case (p)
                0: begin
                    coarseData[k] = 8'd2;
                    fineData[k] = a[0] ? 8'd15 : 8'd0;
                end
                1: begin
                    coarseData[k] = 8'd9;
                    fineData[k] = 8'd15;
                end
                2: begin
                    coarseData[k] = 8'd245;
                    fineData[k] = 8'd247;
                end
                default: begin
                    coarseData[k] = 8'd255;
                    fineData[k] = (a < 3) ? 8'd232 : 8'd247;
                end
            endcase
        end
        runFrame("clamp", 0);
    endtask

    // window 72..87 for every pixel, pixel 0 never hits it
    task automatic testOutliers();
        int p;
        int s;
        int a;
        for (int k = 0; k < PASS_LEN; k++) begin
            p = (k / `SIFH_DATA_NUM) % `SIFH_PIXELS;
            s = k % `SIFH_DATA_NUM;
            a = k / (`SIFH_DATA_NUM * `SIFH_PIXELS);
            coarseData[k] = 8'h55;
            case (p)
                0: fineData[k] = s ? 8'd88 : 8'd71;
                1: fineData[k] = s ? 8'd200 : 8'd80;
                2: fineData[k] = s ? 8'd10 : 8'(72 + a);
                default: fineData[k] = s ? 8'(87 - a) : 8'd87;
            endcase
        end
        runFrame("outliers", 0);
    endtask

    // fine data spread around each window, some of it outside
    task automatic testRandom();
        logic [7:0] r;
        int p;
        for (int f = 0; f < 3; f++) begin
            for (int k = 0; k < PASS_LEN; k++) begin
                takeBits(8, coarseData[k]);
            end
            modelPass(0);
            for (int k = 0; k < PASS_LEN; k++) begin
                p = (k / `SIFH_DATA_NUM) % `SIFH_PIXELS;
                takeBits(5, r);
                fineData[k] = 8'(loModel[p] + int'(r) - 8);
            end
            runFrame($sformatf("random%0d", f), 1);
        end
    endtask

    initial begin
        clk = 0;
        combin_res = 0;
        wrEn = 0;
        data = '0;
        lfsr = 32'h5840_c9f2;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        timedOut = 0;
        repeat (5) @(posedge clk);
        #1;
        combin_res = 1;
        testReset();
        testClustered();
        testClamp();
        testOutliers();
        testRandom();
        $display("%0d tests run, %0d failed, %0d mismatches", testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0 && !timedOut) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: dv/sifhTop_chk.sv
/* assertions on the top-level strobes, bound into every sifhTop instance */
`timescale 1ns/1ps

module sifhChk (
    input logic clk,
    input logic combin_res,
    input logic ready,
    input logic resultValid
);

    // one strobe per frame
    resultPulse: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |=> !resultValid)
        else $error("resultValid high for more than one cycle");

    // results come out of the publish state, ready low there
    resultAfterPublish: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |-> $past(!ready))
        else $error("resultValid not preceded by a cycle with ready low");

    // FSM parked in COARSE while reset is held
    resetValues: assert property (@(posedge clk)
        !combin_res |-> (ready && !resultValid))
        else $error("ready or resultValid away from reset value during reset");

endmodule

bind sifhTop sifhChk chk (
    .clk(clk), .combin_res(combin_res), .ready(ready), .resultValid(resultValid)
);

// File: hw/sifhHistPeak.sv
/* per-pixel histograms with a valid bit per bin and a running peak,
   cleared in one cycle by clearHist */
`timescale 1ns/1ps
`include "sifh_consts.svh"

module sifhHistPeak import sifhPkg::*; (
    input  logic                       clk,
    input  logic                       combin_res,
    sifhSampleIf.dst                   smp,
    input  logic                       clearHist,
    output binIdx_t [`SIFH_PIXELS-1:0] peakBins,
    output logic                       passDone
);

    localparam int BINS = 1 << `SIFH_NB;

    // bin storage, contents only meaningful where the valid bit is set
    binCount_t binCnt [`SIFH_PIXELS][BINS];
    logic [BINS-1:0] binValid [`SIFH_PIXELS];

    // running best per pixel
    binCount_t bestCnt [`SIFH_PIXELS];

    binCount_t curCnt;
    binCount_t newCnt;
    logic lastSeen;

    // an invalid bin reads as zero
    // array is written in place, so a back to back hit sees the fresh count
    always_comb begin
        curCnt = binValid[smp.pixel][smp.bin] ? binCnt[smp.pixel][smp.bin] : '0;
        newCnt = curCnt + 1'b1;
    end

    // ******************************
    // stage 2, count and peak
    // ******************************
    always_ff @(posedge clk) begin
        if (smp.valid) begin
            binCnt[smp.pixel][smp.bin] <= newCnt;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                binValid[p] <= '0;
                bestCnt[p]  <= '0;
                peakBins[p] <= '0;
            end
        end else if (clearHist) begin
            // whole histogram emptied at once
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                binValid[p] <= '0;
                bestCnt[p]  <= '0;
                peakBins[p] <= '0;
            end
        end else if (smp.valid) begin
            binValid[smp.pixel][smp.bin] <= 1'b1;
            // strictly greater, earliest bin wins a tie
            if (newCnt > bestCnt[smp.pixel]) begin
                bestCnt[smp.pixel]  <= newCnt;
                peakBins[smp.pixel] <= smp.bin;
            end
        end
    end

    // end of pass, flagged once the last beat has been counted
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            lastSeen <= 1'b0;
            passDone <= 1'b0;
        end else begin
            lastSeen <= smp.last;
            passDone <= lastSeen;
        end
    end

endmodule

// File: hw/sifhPassFsm.sv
/* pass sequencer: coarse pass, window load, fine pass, publish.
   the only block that decides when samples are taken and histograms emptied */
`timescale 1ns/1ps

module sifhPassFsm import sifhPkg::*; (
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    input  logic lastSample,
    input  logic passDone,
    output logic ready,
    output logic fine,
    output logic loadWindow,
    output logic clearHist,
    output logic publish
);

    passState_t state;
    passState_t nextState;
    logic accept;

    // samples only taken in the two collecting states
    assign accept = wrEn && ready;

    always_comb begin
        nextState = state;
        case (state)
            COARSE:       if (accept && lastSample) nextState = COARSE_DRAIN;
            // wait for the last beat to be counted
            COARSE_DRAIN: if (passDone) nextState = WINDOW;
            WINDOW:       nextState = FINE;
            FINE:         if (accept && lastSample) nextState = FINE_DRAIN;
            FINE_DRAIN:   if (passDone) nextState = PUBLISH;
            PUBLISH:      nextState = COARSE;
            default:      nextState = COARSE;
        endcase
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= COARSE;
        end else begin
            state <= nextState;
        end
    end

    // ******************************
    // state decodes
    // ******************************
    assign ready = (state == COARSE) || (state == FINE);
    assign fine  = (state == FINE);
    // single cycle states, so these are one-clock pulses
    assign loadWindow = (state == WINDOW);
    assign publish    = (state == PUBLISH);
    // empty before the fine pass and again after publishing
    assign clearHist  = (state == WINDOW) || (state == PUBLISH);

endmodule

// File: hw/sifhPkg.sv
/* shared types of the peak finder, pulled in by a wildcard import
   in each module header */
`include "sifh_consts.svh"

package sifhPkg;

    // raw time of arrival
    typedef logic [`SIFH_NP-1:0] timeStamp_t;

    // coarse or fine histogram bin
    typedef logic [`SIFH_NB-1:0] binIdx_t;

    // hits in one bin
    typedef logic [`SIFH_CNT_W-1:0] binCount_t;

    // which pixel a sample belongs to
    typedef logic [$clog2(`SIFH_PIXELS)-1:0] pixelIdx_t;

    // pass sequencing
    typedef enum logic [2:0] {
        COARSE,
        COARSE_DRAIN,
        WINDOW,
        FINE,
        FINE_DRAIN,
        PUBLISH
    } passState_t;

endpackage

// File: hw/sifhSampleIf.sv
/* one filtered sample travelling from the window filter to the histogram,
   no handshake, every valid beat is counted */
`timescale 1ns/1ps

interface sifhSampleIf import sifhPkg::*; ();

    // sample falls in a histogram bin
    logic valid;
    binIdx_t bin;
    pixelIdx_t pixel;
    // final sample of the pass, also on a dropped beat
    logic last;

    // filter side
    modport src (
        output valid, bin, pixel, last
    );

    // histogram side
    modport dst (
        input valid, bin, pixel, last
    );

endinterface

// File: hw/sifhSeqCounter.sv
/* nested sample / pixel / acquisition counters, flags the last sample
   of a pass so the FSM and the filter see it on the same accept */
`timescale 1ns/1ps
`include "sifh_consts.svh"

module sifhSeqCounter import sifhPkg::*; (
    input  logic      clk,
    input  logic      combin_res,
    input  logic      accept,
    output pixelIdx_t pixel,
    output logic      lastSample
);

    localparam int SMP_W = $clog2(`SIFH_DATA_NUM);
    localparam int ACQ_W = $clog2(`SIFH_ACQ_NUM);

    logic [SMP_W-1:0] smpCnt;
    logic [ACQ_W-1:0] acqCnt;
    logic smpWrap;
    logic pixWrap;
    logic acqWrap;

    // wrap points, sample runs fastest
    assign smpWrap = (smpCnt == SMP_W'(`SIFH_DATA_NUM - 1));
    assign pixWrap = (pixel == pixelIdx_t'(`SIFH_PIXELS - 1));
    assign acqWrap = (acqCnt == ACQ_W'(`SIFH_ACQ_NUM - 1));
    assign lastSample = smpWrap && pixWrap && acqWrap;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            smpCnt <= '0;
            pixel  <= '0;
            acqCnt <= '0;
        end else if (accept) begin
            smpCnt <= smpWrap ? '0 : smpCnt + 1'b1;
            // pixel steps once its samples are done
            if (smpWrap) begin
                pixel <= pixWrap ? '0 : pixel + 1'b1;
                // then the acquisition
                if (pixWrap) begin
                    acqCnt <= acqWrap ? '0 : acqCnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/sifhTop.sv
/* two-pass histogram peak finder, top level.
   feed samples with wrEn while ready is high, results arrive with resultValid */
`timescale 1ns/1ps
`include "sifh_consts.svh"

module sifhTop import sifhPkg::*; (
    input  logic                               clk,
    input  logic                               combin_res,
    input  logic                               wrEn,
    input  logic [`SIFH_NP-1:0]                data,
    output logic                               ready,
    output logic [`SIFH_PIXELS*`SIFH_NP-1:0]   result,
    output logic                               resultValid
);

    // ******************************
    // internal links
    // ******************************
    logic accept;
    pixelIdx_t pixel;
    logic lastSample;
    logic fine;
    logic loadWindow;
    logic clearHist;
    logic publish;
    logic passDone;
    binIdx_t [`SIFH_PIXELS-1:0] peakBins;

    // filter to histogram
    sifhSampleIf smpIf ();

    // a sample counts only while ready is high
    assign accept = wrEn && ready;

    sifhSeqCounter uSeq (
        .clk(clk), .combin_res(combin_res), .accept(accept),
        .pixel(pixel), .lastSample(lastSample)
    );

    sifhPassFsm uFsm (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn),
        .lastSample(lastSample), .passDone(passDone), .ready(ready),
        .fine(fine), .loadWindow(loadWindow), .clearHist(clearHist),
        .publish(publish)
    );

    sifhWindowFilter uFilter (
        .clk(clk), .combin_res(combin_res), .data(data), .accept(accept),
        .pixel(pixel), .lastSample(lastSample), .fine(fine),
        .loadWindow(loadWindow), .publish(publish), .peakBins(peakBins),
        .smp(smpIf.src), .result(result), .resultValid(resultValid)
    );

    sifhHistPeak uHist (
        .clk(clk), .combin_res(combin_res), .smp(smpIf.dst),
        .clearHist(clearHist), .peakBins(peakBins), .passDone(passDone)
    );

endmodule

// File: hw/sifhWindowFilter.sv
/* maps accepted samples to coarse or fine bins, keeps the per-pixel fine
   windows and rebuilds the published timestamps from the fine peaks */
`timescale 1ns/1ps
`include "sifh_consts.svh"

module sifhWindowFilter import sifhPkg::*; (
    input  logic                          clk,
    input  logic                          combin_res,
    input  timeStamp_t                    data,
    input  logic                          accept,
    input  pixelIdx_t                     pixel,
    input  logic                          lastSample,
    input  logic                          fine,
    input  logic                          loadWindow,
    input  logic                          publish,
    input  binIdx_t [`SIFH_PIXELS-1:0]    peakBins,
    sifhSampleIf.src                      smp,
    output timeStamp_t [`SIFH_PIXELS-1:0] result,
    output logic                          resultValid
);

    localparam int BINS = 1 << `SIFH_NB;
    localparam int MAX_LO = (1 << `SIFH_NP) - BINS;

    timeStamp_t winLo [`SIFH_PIXELS];
    timeStamp_t curLo;
    timeStamp_t offset;
    logic inWin;

    // coarse peak * 16 - half window, kept inside the timestamp range
    function automatic timeStamp_t winStart(binIdx_t pk);
        int base;
        base = int'(pk) * (1 << (`SIFH_NP - `SIFH_NB)) - `SIFH_HALF_WIN;
        if (base < 0) begin
            base = 0;
        end else if (base > MAX_LO) begin
            base = MAX_LO;
        end
        return timeStamp_t'(base);
    endfunction

    // window hit test for the current pixel
    always_comb begin
        curLo  = winLo[pixel];
        offset = data - curLo;
        inWin  = (data >= curLo) && (offset < timeStamp_t'(BINS));
    end

    // ******************************
    // stage 1, sample register
    // ******************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            smp.valid <= 1'b0;
            smp.last  <= 1'b0;
        end else begin
            // out of window samples still carry last
            smp.valid <= accept && (!fine || inWin);
            smp.last  <= accept && lastSample;
        end
    end

    always_ff @(posedge clk) begin
        smp.pixel <= pixel;
        smp.bin   <= fine ? offset[`SIFH_NB-1:0] : data[`SIFH_NP-1 -: `SIFH_NB];
    end

    // windows and published results
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                winLo[p]  <= '0;
                result[p] <= '0;
            end
            resultValid <= 1'b0;
        end else begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                if (loadWindow) winLo[p] <= winStart(peakBins[p]);
                // fine peak offset back to absolute time
                if (publish) result[p] <= winLo[p] + timeStamp_t'(peakBins[p]);
            end
            resultValid <= publish;
        end
    end

endmodule

// File: include/sifh_consts.svh
/* sizing constants for the two-pass peak finder.
   included by the package and by every block that needs a width or a count */
`ifndef SIFH_CONSTS_SVH
`define SIFH_CONSTS_SVH

// ******************************
// sample format
// ******************************
// timestamp width
`define SIFH_NP 8
// bin index width, 16 bins per histogram
`define SIFH_NB 4

// ******************************
// frame shape
// ******************************
`define SIFH_PIXELS 4
`define SIFH_DATA_NUM 2
// 32 samples per pass
`define SIFH_ACQ_NUM 4
// counts up to one full pass
`define SIFH_CNT_W 6
`define SIFH_HALF_WIN 8

`endif

// File: run.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sifhTb -f all.f -o sifhSim \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sifhSim > sim.log 2>&1; cat sim.log
grep -q "^Simulation passed$" sim.log && echo "run ok" || { echo "run failed"; exit 1; }
